//--- Bender.yml
package:
  name: pcpu

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mips_isa_pkg.sv
      - logic/pcpu_ctrl_pkg.sv
      - logic/pcpu_stage_if.sv
      - logic/pcpu_regfile.sv
      - logic/pcpu_decode.sv
      - logic/pcpu_execute.sv
      - logic/pcpu_result.sv
      - logic/pcpu_hazard.sv
      - logic/pcpu_top.sv
  - target: simulation
    include_dirs:
      - logic
      - verification
    files:
      - verification/pcpu_tb.sv

//--- flist.f
+incdir+logic
+incdir+verification
logic/mips_isa_pkg.sv
logic/pcpu_ctrl_pkg.sv
logic/pcpu_stage_if.sv
logic/pcpu_regfile.sv
logic/pcpu_decode.sv
logic/pcpu_execute.sv
logic/pcpu_result.sv
logic/pcpu_hazard.sv
logic/pcpu_top.sv
verification/pcpu_tb.sv

//--- logic/mips_isa_pkg.sv
// MIPS32 subset encoding: major opcodes, special function codes, register index

`default_nettype none

`include "pcpu_params.svh"

package mips_isa_pkg;

    // major opcode, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // function field of special instructions, instr[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_e;

    typedef logic [`PCPU_REG_ADDR_W-1:0] reg_idx_t;

endpackage

`default_nettype wire

//--- logic/pcpu_ctrl_pkg.sv
// pipeline control types: ALU operation, forwarding select, control word

`default_nettype none

package pcpu_ctrl_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_lui
    } alu_op_e;

    // execute operand source
    typedef enum logic [1:0] {
        fwd_none,   // value read in decode
        fwd_mem,    // alu result in memory stage
        fwd_wb      // writeback data
    } fwd_sel_e;

    // all zero means bubble
    typedef struct packed {
        logic    reg_write;
        logic    reg_dst;     // 1: rd, 0: rt
        logic    alu_src;     // 1: immediate
        alu_op_e alu_op;
        logic    mem_write;
        logic    mem_to_reg;
    } ctrl_word_t;

endpackage

`default_nettype wire

//--- logic/pcpu_decode.sv
// fetch and decode stages: PC, F/D border, control decoder, early branch, D/E border

`default_nettype none

`include "pcpu_params.svh"

module pcpu_decode
    import mips_isa_pkg::*, pcpu_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`PCPU_XLEN-1:0] im_data,
    input  reg_idx_t              reg_addr,
    input  logic                  stall,
    input  logic                  fwd_a_d,
    input  logic                  fwd_b_d,
    input  logic [`PCPU_XLEN-1:0] wb_data,
    input  reg_idx_t              wb_dest,
    input  logic                  wb_en,
    output logic [`PCPU_XLEN-1:0] im_addr,
    output logic [`PCPU_XLEN-1:0] reg_data,
    output reg_idx_t              rs_d,
    output reg_idx_t              rt_d,
    output logic                  branch_d,
    dx_if.decode                  dx,
    xr_if.fwd                     xr
);
    // ************************************************************************
    // fetch
    // ************************************************************************

    logic [`PCPU_XLEN-1:0] pc;
    logic [`PCPU_XLEN-1:0] pc_next;
    logic [`PCPU_XLEN-1:0] pc_target;
    logic                  pc_src;      // taken branch in decode
    logic [`PCPU_XLEN-1:0] instr_d;
    logic [`PCPU_XLEN-1:0] pc_plus_d;

    assign pc_next = pc + 1'b1;         // word addressed
    assign im_addr = pc;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= `PCPU_PC_RESET;
        else if (!stall)
            pc <= pc_src ? pc_target : pc_next;
    end

    // F/D border, a taken branch squashes the fetched word
    always_ff @(posedge clk) begin
        if (reset)
            instr_d <= '0;
        else if (!stall)
            instr_d <= pc_src ? '0 : im_data;
    end

    always_ff @(posedge clk) begin
        if (!stall)
            pc_plus_d <= pc_next;
    end

    // ************************************************************************
    // decode
    // ************************************************************************

    opcode_e               op_d;
    funct_e                fn_d;
    reg_idx_t              rd_d;
    logic [`PCPU_XLEN-1:0] imm_d;
    logic [`PCPU_XLEN-1:0] rs_rf;
    logic [`PCPU_XLEN-1:0] rt_rf;
    logic [`PCPU_XLEN-1:0] rs_fwd;
    logic [`PCPU_XLEN-1:0] rt_fwd;
    logic [`PCPU_XLEN-1:0] dbg_val;
    ctrl_word_t            ctrl_d;
    logic                  is_beq;
    logic                  is_bne;

    assign op_d  = opcode_e'(instr_d[31:26]);
    assign fn_d  = funct_e'(instr_d[5:0]);
    assign rs_d  = instr_d[25:21];
    assign rt_d  = instr_d[20:16];
    assign rd_d  = instr_d[15:11];
    assign imm_d = {{(`PCPU_XLEN-16){instr_d[15]}}, instr_d[15:0]};

    pcpu_regfile regfile0 (
        .clk      (clk),
        .reset    (reset),
        .rs_addr  (rs_d),
        .rt_addr  (rt_d),
        .dbg_addr (reg_addr),
        .wr_addr  (wb_dest),
        .wr_data  (wb_data),
        .wr_en    (wb_en),
        .rs_val   (rs_rf),
        .rt_val   (rt_rf),
        .dbg_val  (dbg_val)
    );

    assign reg_data = (reg_addr != '0) ? dbg_val : pc;   // r0 slot shows the pc

    assign rs_fwd = fwd_a_d ? xr.alu_result : rs_rf;
    assign rt_fwd = fwd_b_d ? xr.alu_result : rt_rf;

    always_comb begin
        ctrl_d = '0;
        is_beq = 1'b0;
        is_bne = 1'b0;
        case (op_d)
            op_special: begin
                ctrl_d.reg_write = 1'b1;
                ctrl_d.reg_dst   = 1'b1;
                case (fn_d)
                    fn_addu: ctrl_d.alu_op = alu_add;
                    fn_subu: ctrl_d.alu_op = alu_sub;
                    fn_and:  ctrl_d.alu_op = alu_and;
                    fn_or:   ctrl_d.alu_op = alu_or;
                    fn_slt:  ctrl_d.alu_op = alu_slt;
                    fn_sll:  ctrl_d.alu_op = alu_sll;
                    fn_srl:  ctrl_d.alu_op = alu_srl;
                    default: ctrl_d.reg_write = 1'b0;   // unsupported, acts as nop
                endcase
            end
            op_addiu: begin
                ctrl_d.reg_write = 1'b1;
                ctrl_d.alu_src   = 1'b1;
            end
            op_lui: begin
                ctrl_d.reg_write = 1'b1;
                ctrl_d.alu_src   = 1'b1;
                ctrl_d.alu_op    = alu_lui;
            end
            op_lw: begin
                ctrl_d.reg_write  = 1'b1;
                ctrl_d.alu_src    = 1'b1;
                ctrl_d.mem_to_reg = 1'b1;
            end
            op_sw: begin
                ctrl_d.alu_src   = 1'b1;
                ctrl_d.mem_write = 1'b1;
            end
            op_beq: is_beq = 1'b1;
            op_bne: is_bne = 1'b1;
            default: ;
        endcase
    end

    // early branch on forwarded operands
    assign branch_d  = is_beq || is_bne;
    assign pc_target = pc_plus_d + imm_d;
    assign pc_src    = (is_beq && rs_fwd == rt_fwd) || (is_bne && rs_fwd != rt_fwd);

    // D/E border, bubble while stalled
    always_ff @(posedge clk) begin
        if (reset || stall)
            dx.ctrl <= '0;
        else
            dx.ctrl <= ctrl_d;
    end

    always_ff @(posedge clk) begin
        dx.rs_val <= rs_fwd;
        dx.rt_val <= rt_fwd;
        dx.imm    <= imm_d;
        dx.rs     <= rs_d;
        dx.rt     <= rt_d;
        dx.rd     <= rd_d;
        dx.shamt  <= instr_d[10:6];
    end

endmodule

`default_nettype wire

//--- logic/pcpu_execute.sv
// execute stage: operand forwarding, ALU, destination select, E/M border

`default_nettype none

`include "pcpu_params.svh"

module pcpu_execute
    import mips_isa_pkg::*, pcpu_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  fwd_sel_e              fwd_a_e,
    input  fwd_sel_e              fwd_b_e,
    input  logic [`PCPU_XLEN-1:0] wb_data,
    output reg_idx_t              dest_e,
    dx_if.execute                 dx,
    xr_if.execute                 xr
);
    logic [`PCPU_XLEN-1:0] src_a;
    logic [`PCPU_XLEN-1:0] src_b_reg;   // also the store data
    logic [`PCPU_XLEN-1:0] src_b;
    logic [`PCPU_XLEN-1:0] alu_out;

    function automatic logic [`PCPU_XLEN-1:0] pick_operand(
        input fwd_sel_e              sel,
        input logic [`PCPU_XLEN-1:0] reg_val,
        input logic [`PCPU_XLEN-1:0] mem_val,
        input logic [`PCPU_XLEN-1:0] wb_val
    );
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // ************************************************************************
    // operands and ALU
    // ************************************************************************

    assign src_a     = pick_operand(fwd_a_e, dx.rs_val, xr.alu_result, wb_data);
    assign src_b_reg = pick_operand(fwd_b_e, dx.rt_val, xr.alu_result, wb_data);
    assign src_b     = dx.ctrl.alu_src ? dx.imm : src_b_reg;

    always_comb begin
        case (dx.ctrl.alu_op)
            alu_add: alu_out = src_a + src_b;
            alu_sub: alu_out = src_a - src_b;
            alu_and: alu_out = src_a & src_b;
            alu_or:  alu_out = src_a | src_b;
            alu_slt: alu_out = {{(`PCPU_XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            alu_sll: alu_out = src_b << dx.shamt;    // shifts act on rt
            alu_srl: alu_out = src_b >> dx.shamt;
            alu_lui: alu_out = {src_b[15:0], 16'h0000};
            default: alu_out = '0;
        endcase
    end

    assign dest_e = dx.ctrl.reg_dst ? dx.rd : dx.rt;

    // ************************************************************************
    // E/M border
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (reset)
            xr.ctrl <= '0;
        else
            xr.ctrl <= dx.ctrl;
    end

    always_ff @(posedge clk) begin
        xr.alu_result <= alu_out;
        xr.store_data <= src_b_reg;
        xr.dest       <= dest_e;
    end

endmodule

`default_nettype wire

//--- logic/pcpu_hazard.sv
// hazard unit: forwarding selects for execute and branch compare, stall detection

`default_nettype none

module pcpu_hazard
    import mips_isa_pkg::*, pcpu_ctrl_pkg::*;
(
    input  reg_idx_t rs_d,
    input  reg_idx_t rt_d,
    input  logic     branch_d,
    input  reg_idx_t dest_e,
    input  reg_idx_t wb_dest,
    input  logic     wb_en,
    output logic     stall,
    output fwd_sel_e fwd_a_e,
    output fwd_sel_e fwd_b_e,
    output logic     fwd_a_d,
    output logic     fwd_b_d,
    dx_if.hazard     dx,
    xr_if.fwd        xr
);
    logic mem_wr;     // memory stage writes a real register
    logic wb_wr;
    logic exe_wr;
    logic load_use;
    logic branch_wait;

    // memory stage is younger, so it wins
    function automatic fwd_sel_e exec_src(
        input reg_idx_t src,
        input reg_idx_t m_dest,
        input logic     m_wr,
        input reg_idx_t w_dest,
        input logic     w_wr
    );
        if (m_wr && m_dest == src)
            return fwd_mem;
        if (w_wr && w_dest == src)
            return fwd_wb;
        return fwd_none;
    endfunction

    assign mem_wr = xr.ctrl.reg_write && xr.dest != '0;
    assign wb_wr  = wb_en && wb_dest != '0;
    assign exe_wr = dx.ctrl.reg_write && dest_e != '0;

    assign fwd_a_e = exec_src(dx.rs, xr.dest, mem_wr, wb_dest, wb_wr);
    assign fwd_b_e = exec_src(dx.rt, xr.dest, mem_wr, wb_dest, wb_wr);

    // decode only sees the memory stage
    assign fwd_a_d = mem_wr && xr.dest == rs_d;
    assign fwd_b_d = mem_wr && xr.dest == rt_d;

    assign load_use = dx.ctrl.mem_to_reg && exe_wr && (dest_e == rs_d || dest_e == rt_d);

    // branch operand not ready yet for the decode compare
    assign branch_wait = branch_d && (
        (exe_wr && (dest_e == rs_d || dest_e == rt_d)) ||
        (xr.ctrl.mem_to_reg && mem_wr && (xr.dest == rs_d || xr.dest == rt_d)));

    assign stall = load_use || branch_wait;

endmodule

`default_nettype wire

//--- logic/pcpu_params.svh
// data width, register file size and reset address macros

`ifndef PCPU_PARAMS_SVH
`define PCPU_PARAMS_SVH

// one word wide datapath, word addressed memories
`define PCPU_XLEN 32

// register file geometry
`define PCPU_REG_COUNT 32
`define PCPU_REG_ADDR_W 5

// first fetch address
`define PCPU_PC_RESET 32'h0000_0000

`endif

//--- logic/pcpu_regfile.sv
// 32-entry register file with write-through reads and a debug read port

`default_nettype none

`include "pcpu_params.svh"

module pcpu_regfile
    import mips_isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  reg_idx_t              rs_addr,
    input  reg_idx_t              rt_addr,
    input  reg_idx_t              dbg_addr,
    input  reg_idx_t              wr_addr,
    input  logic [`PCPU_XLEN-1:0] wr_data,
    input  logic                  wr_en,
    output logic [`PCPU_XLEN-1:0] rs_val,
    output logic [`PCPU_XLEN-1:0] rt_val,
    output logic [`PCPU_XLEN-1:0] dbg_val
);
    logic [`PCPU_XLEN-1:0] regs [`PCPU_REG_COUNT];

    // r0 is hardwired, a same-cycle write wins over the stored word
    function automatic logic [`PCPU_XLEN-1:0] read_port(
        input reg_idx_t              addr,
        input logic [`PCPU_XLEN-1:0] stored,
        input logic                  hit,
        input logic [`PCPU_XLEN-1:0] data
    );
        if (addr == '0)
            return '0;
        return hit ? data : stored;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `PCPU_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_val  = read_port(rs_addr, regs[rs_addr], wr_en && wr_addr == rs_addr, wr_data);
    assign rt_val  = read_port(rt_addr, regs[rt_addr], wr_en && wr_addr == rt_addr, wr_data);
    assign dbg_val = read_port(dbg_addr, regs[dbg_addr], wr_en && wr_addr == dbg_addr, wr_data);

endmodule

`default_nettype wire

//--- logic/pcpu_result.sv
// memory and writeback stages: data memory drive, M/W border, writeback select

`default_nettype none

`include "pcpu_params.svh"

module pcpu_result
    import mips_isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`PCPU_XLEN-1:0] dm_rdata,
    output logic [`PCPU_XLEN-1:0] dm_addr,
    output logic                  dm_we,
    output logic [`PCPU_XLEN-1:0] dm_wdata,
    output logic [`PCPU_XLEN-1:0] wb_data,
    output reg_idx_t              wb_dest,
    output logic                  wb_en,
    xr_if.result                  xr
);
    logic [`PCPU_XLEN-1:0] alu_w;
    logic [`PCPU_XLEN-1:0] load_w;
    logic                  mem_to_reg_w;

    // memory stage drives the data port directly
    assign dm_addr  = xr.alu_result;
    assign dm_we    = xr.ctrl.mem_write;
    assign dm_wdata = xr.store_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_en        <= 1'b0;
            mem_to_reg_w <= 1'b0;
        end else begin
            wb_en        <= xr.ctrl.reg_write;
            mem_to_reg_w <= xr.ctrl.mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        alu_w   <= xr.alu_result;
        load_w  <= dm_rdata;    // sampled while the load sits in memory
        wb_dest <= xr.dest;
    end

    assign wb_data = mem_to_reg_w ? load_w : alu_w;

endmodule

`default_nettype wire

//--- logic/pcpu_stage_if.sv
// decode/execute and execute/memory stage border interfaces

`default_nettype none

`include "pcpu_params.svh"

interface dx_if
    import mips_isa_pkg::*, pcpu_ctrl_pkg::*;
();
    logic [`PCPU_XLEN-1:0] rs_val;   // already forwarded in decode
    logic [`PCPU_XLEN-1:0] rt_val;
    logic [`PCPU_XLEN-1:0] imm;      // sign extended
    reg_idx_t              rs;
    reg_idx_t              rt;
    reg_idx_t              rd;
    logic [4:0]            shamt;
    ctrl_word_t            ctrl;

    modport decode  (output rs_val, rt_val, imm, rs, rt, rd, shamt, ctrl);
    modport execute (input rs_val, rt_val, imm, rt, rd, shamt, ctrl);
    modport hazard  (input rs, rt, ctrl);
endinterface

interface xr_if
    import mips_isa_pkg::*, pcpu_ctrl_pkg::*;
();
    logic [`PCPU_XLEN-1:0] alu_result;
    logic [`PCPU_XLEN-1:0] store_data;
    reg_idx_t              dest;
    ctrl_word_t            ctrl;

    modport execute (output alu_result, store_data, dest, ctrl);
    modport result  (input alu_result, store_data, dest, ctrl);
    // memory stage result as seen by the forwarding paths
    modport fwd     (input alu_result, dest, ctrl);
endinterface

`default_nettype wire

//--- logic/pcpu_top.sv
// pipelined MIPS core top: decode, execute, result and hazard blocks

`default_nettype none

`include "pcpu_params.svh"

module pcpu_top
    import mips_isa_pkg::*, pcpu_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  reg_idx_t              reg_addr,   // debug register select
    output logic [`PCPU_XLEN-1:0] reg_data,
    output logic [`PCPU_XLEN-1:0] im_addr,
    input  logic [`PCPU_XLEN-1:0] im_data,
    output logic [`PCPU_XLEN-1:0] dm_addr,
    output logic                  dm_we,
    output logic [`PCPU_XLEN-1:0] dm_wdata,
    input  logic [`PCPU_XLEN-1:0] dm_rdata
);
    // ************************************************************************
    // stage links
    // ************************************************************************

    dx_if dx ();
    xr_if xr ();

    logic                  stall;
    fwd_sel_e              fwd_a_e;
    fwd_sel_e              fwd_b_e;
    logic                  fwd_a_d;
    logic                  fwd_b_d;
    reg_idx_t              rs_d;
    reg_idx_t              rt_d;
    logic                  branch_d;
    reg_idx_t              dest_e;
    logic [`PCPU_XLEN-1:0] wb_data;
    reg_idx_t              wb_dest;
    logic                  wb_en;

    pcpu_decode decode0 (
        .clk      (clk),
        .reset    (reset),
        .im_data  (im_data),
        .reg_addr (reg_addr),
        .stall    (stall),
        .fwd_a_d  (fwd_a_d),
        .fwd_b_d  (fwd_b_d),
        .wb_data  (wb_data),
        .wb_dest  (wb_dest),
        .wb_en    (wb_en),
        .im_addr  (im_addr),
        .reg_data (reg_data),
        .rs_d     (rs_d),
        .rt_d     (rt_d),
        .branch_d (branch_d),
        .dx       (dx.decode),
        .xr       (xr.fwd)
    );

    pcpu_execute execute0 (
        .clk     (clk),
        .reset   (reset),
        .fwd_a_e (fwd_a_e),
        .fwd_b_e (fwd_b_e),
        .wb_data (wb_data),
        .dest_e  (dest_e),
        .dx      (dx.execute),
        .xr      (xr.execute)
    );

    pcpu_result result0 (
        .clk      (clk),
        .reset    (reset),
        .dm_rdata (dm_rdata),
        .dm_addr  (dm_addr),
        .dm_we    (dm_we),
        .dm_wdata (dm_wdata),
        .wb_data  (wb_data),
        .wb_dest  (wb_dest),
        .wb_en    (wb_en),
        .xr       (xr.result)
    );

    pcpu_hazard hazard0 (
        .rs_d     (rs_d),
        .rt_d     (rt_d),
        .branch_d (branch_d),
        .dest_e   (dest_e),
        .wb_dest  (wb_dest),
        .wb_en    (wb_en),
        .stall    (stall),
        .fwd_a_e  (fwd_a_e),
        .fwd_b_e  (fwd_b_e),
        .fwd_a_d  (fwd_a_d),
        .fwd_b_d  (fwd_b_d),
        .dx       (dx.hazard),
        .xr       (xr.fwd)
    );

endmodule

`default_nettype wire

//--- verification/pcpu_tb_tasks.svh
// program builder, reset and halt handling, compare tasks and the directed tests

`ifndef PCPU_TB_TASKS_SVH
`define PCPU_TB_TASKS_SVH

function automatic logic [`PCPU_XLEN-1:0] fill_word(input int unsigned addr);
    return 32'hd00d_0000 | addr;   // whole address shows in the word
endfunction

task automatic push_rtype(
    input funct_e     fn,
    input reg_idx_t   rd,
    input reg_idx_t   rs,
    input reg_idx_t   rt,
    input logic [4:0] sh
);
    prog.push_back({op_special, rs, rt, rd, sh, fn});
endtask

// assembler operand order is op rt, rs, imm
task automatic push_itype(
    input opcode_e     op,
    input reg_idx_t    rt,
    input reg_idx_t    rs,
    input logic [15:0] imm
);
    prog.push_back({op, rs, rt, imm});
endtask

task automatic load_program();
    @(negedge clk);
    for (int i = 0; i < IMEM_WORDS; i++)
        imem[i] = '0;
    foreach (prog[i])
        imem[i] = prog[i];
    halt_addr = prog.size();
    imem[prog.size()] = {op_beq, 5'd0, 5'd0, 16'hffff};   // beq r0, r0, -1
    for (int i = 0; i < DMEM_WORDS; i++)
        dmem[i] = fill_word(i);
    prog.delete();
endtask

// ****************************************************************************
// compare tasks
// ****************************************************************************

task automatic report_mismatch(
    input string                 what,
    input logic [`PCPU_XLEN-1:0] got,
    input logic [`PCPU_XLEN-1:0] exp
);
    $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
    $display("Test failed");
    $fatal(1, "stopped at first mismatch");
endtask

task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp)
        report_mismatch(what, {31'b0, got}, {31'b0, exp});
endtask

// debug port already set to address 0
task automatic check_pc(input logic [`PCPU_XLEN-1:0] exp);
    if (reg_data !== exp)
        report_mismatch("pc on debug port", reg_data, exp);
endtask

task automatic check_reg(input reg_idx_t idx, input logic [`PCPU_XLEN-1:0] exp);
    @(negedge clk);
    reg_addr = idx;
    #1;
    if (reg_data !== exp)
        report_mismatch($sformatf("register r%0d", idx), reg_data, exp);
endtask

task automatic check_mem(input int unsigned addr, input logic [`PCPU_XLEN-1:0] exp);
    if (dmem[addr] !== exp)
        report_mismatch($sformatf("dmem[%0d]", addr), dmem[addr], exp);
endtask

// ****************************************************************************
// reset and run control
// ****************************************************************************

task automatic apply_reset();
    @(negedge clk);
    reset    = 1'b1;
    reg_addr = '0;
    repeat (4) begin
        @(negedge clk);
        check_level("dm_we in reset", dm_we, 1'b0);
        check_pc(`PCPU_PC_RESET);
    end
    reset = 1'b0;
    @(negedge clk);                // first fetch came from the reset address
    check_level("dm_we after reset", dm_we, 1'b0);
    check_pc(`PCPU_PC_RESET + 1);
endtask

// halt seen fetched, then left, then fetched again by its own taken branch
task automatic run_to_halt();
    int cycles;
    int phase;
    cycles = 0;
    phase  = 0;
    while (phase < 3 && cycles < 200) begin
        @(negedge clk);
        cycles++;
        if (phase == 0 && reg_data == halt_addr)
            phase = 1;
        else if (phase == 1 && reg_data != halt_addr)
            phase = 2;
        else if (phase == 2 && reg_data == halt_addr)
            phase = 3;
    end
    if (phase < 3) begin
        $display("program did not reach its halt loop within 200 cycles, time %0t", $time);
        $display("Test failed");
        $fatal(1, "halt timeout");
    end else begin
        repeat (4) @(negedge clk);   // older instructions leave the pipeline
    end
endtask

// ****************************************************************************
// directed tests
// ****************************************************************************

task automatic reset_behavior();
    push_itype(op_addiu, 1, 0, 16'h0055);
    push_itype(op_sw, 1, 0, 16'd2);           // sw r1, 2(r0)
    load_program();
    apply_reset();
    check_mem(2, fill_word(2));                // no store while in reset
    run_to_halt();
    check_mem(2, 32'h0000_0055);
    check_reg(1, 32'h0000_0055);
endtask

task automatic alu_forwarding_chain();
    logic [15:0]           hi_a;
    logic [15:0]           lo_a;
    logic [15:0]           hi_b;
    logic [15:0]           lo_b;
    logic [`PCPU_XLEN-1:0] v [1:11];
    hi_a = 16'($random(seed));
    lo_a = 16'($random(seed));
    hi_b = 16'($random(seed));
    lo_b = 16'($random(seed));
    // lui then addiu with sign-extended low half
    v[1]  = {hi_a, 16'h0000} + {{16{lo_a[15]}}, lo_a};
    v[2]  = {hi_b, 16'h0000} + {{16{lo_b[15]}}, lo_b};
    v[3]  = v[1] + v[2];
    v[4]  = v[3] - v[1];
    v[5]  = v[4] & v[3];
    v[6]  = v[5] | v[2];
    v[7]  = ($signed(v[6]) < $signed(v[4])) ? 32'd1 : 32'd0;
    v[8]  = v[6] << 5;
    v[9]  = v[3] >> 7;
    v[10] = ($signed(v[1]) < $signed(v[2])) ? 32'd1 : 32'd0;
    v[11] = v[9] + 32'hffff_fffd;

    push_itype(op_lui, 1, 0, hi_a);
    push_itype(op_addiu, 1, 1, lo_a);          // needs r1 from memory stage
    push_itype(op_lui, 2, 0, hi_b);
    push_itype(op_addiu, 2, 2, lo_b);
    push_rtype(fn_addu, 3, 1, 2, 5'd0);
    push_rtype(fn_subu, 4, 3, 1, 5'd0);
    push_rtype(fn_and, 5, 4, 3, 5'd0);         // r4 from memory and r3 from writeback
    push_rtype(fn_or, 6, 5, 2, 5'd0);
    push_rtype(fn_slt, 7, 6, 4, 5'd0);
    push_rtype(fn_sll, 8, 0, 6, 5'd5);
    push_rtype(fn_srl, 9, 0, 3, 5'd7);
    push_rtype(fn_slt, 10, 1, 2, 5'd0);
    push_itype(op_addiu, 11, 9, 16'hfffd);
    load_program();
    apply_reset();
    run_to_halt();
    for (int i = 1; i <= 11; i++)
        check_reg(reg_idx_t'(i), v[i]);
endtask

task automatic zero_register_rules();
    push_itype(op_addiu, 0, 0, 16'h1234);      // lost write
    push_rtype(fn_addu, 1, 0, 0, 5'd0);        // r0 one back
    push_itype(op_addiu, 2, 0, 16'd5);
    push_itype(op_lui, 0, 0, 16'hbeef);
    push_rtype(fn_or, 3, 0, 2, 5'd0);
    push_rtype(fn_addu, 4, 0, 0, 5'd0);        // r0 two back
    load_program();
    apply_reset();
    run_to_halt();
    check_reg(1, 32'd0);
    check_reg(2, 32'd5);
    check_reg(3, 32'd5);
    check_reg(4, 32'd0);
endtask

task automatic load_store_roundtrip();
    logic [`PCPU_XLEN-1:0] data;
    logic [`PCPU_XLEN-1:0] r2_val;
    data   = $random(seed);
    r2_val = {data[31:16], 16'h0000} + {{16{data[15]}}, data[15:0]};

    push_itype(op_addiu, 1, 0, 16'h0040);      // base word address
    push_itype(op_lui, 2, 0, data[31:16]);
    push_itype(op_addiu, 2, 2, data[15:0]);
    push_itype(op_sw, 2, 1, 16'd3);
    push_itype(op_lw, 3, 1, 16'd3);            // same word right after the store
    push_rtype(fn_addu, 4, 3, 3, 5'd0);        // load-use
    push_itype(op_sw, 4, 1, 16'd4);
    load_program();
    apply_reset();
    run_to_halt();
    check_mem(32'h43, r2_val);
    check_mem(32'h44, r2_val + r2_val);
    check_mem(32'h45, fill_word(32'h45));
    check_reg(3, r2_val);
    check_reg(4, r2_val + r2_val);
endtask

task automatic branch_paths();
    push_itype(op_addiu, 1, 0, 16'd7);
    push_itype(op_addiu, 2, 0, 16'd7);
    push_itype(op_beq, 2, 1, 16'd2);           // taken on r2 from the line before
    push_itype(op_addiu, 10, 0, 16'd1);        // skipped
    push_itype(op_addiu, 11, 0, 16'd1);        // skipped
    push_itype(op_bne, 2, 1, 16'd1);           // not taken
    push_itype(op_addiu, 12, 0, 16'd1);
    push_itype(op_beq, 0, 1, 16'd1);           // not taken
    push_itype(op_addiu, 13, 0, 16'd1);
    push_itype(op_addiu, 3, 0, 16'd9);
    push_itype(op_bne, 1, 3, 16'd1);           // taken on r3 from the line before
    push_itype(op_addiu, 14, 0, 16'd1);        // skipped
    push_itype(op_addiu, 15, 0, 16'd1);
    load_program();
    apply_reset();
    run_to_halt();
    check_reg(3, 32'd9);
    check_reg(10, 32'd0);
    check_reg(11, 32'd0);
    check_reg(12, 32'd1);
    check_reg(13, 32'd1);
    check_reg(14, 32'd0);
    check_reg(15, 32'd1);
endtask

`endif

//--- verification/pcpu_tb.sv
// testbench top: clock, reset, instruction and data memory models, DUT and test order

`default_nettype none

`include "pcpu_params.svh"

module pcpu_tb
    import mips_isa_pkg::*;
();
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

    logic                  clk;
    logic                  reset;
    reg_idx_t              reg_addr;
    logic [`PCPU_XLEN-1:0] reg_data;
    logic [`PCPU_XLEN-1:0] im_addr;
    logic [`PCPU_XLEN-1:0] im_data;
    logic [`PCPU_XLEN-1:0] dm_addr;
    logic                  dm_we;
    logic [`PCPU_XLEN-1:0] dm_wdata;
    logic [`PCPU_XLEN-1:0] dm_rdata;

    logic [`PCPU_XLEN-1:0] imem [IMEM_WORDS];
    logic [`PCPU_XLEN-1:0] dmem [DMEM_WORDS];
    logic [`PCPU_XLEN-1:0] prog [$];       // program under construction
    logic [`PCPU_XLEN-1:0] halt_addr;
    integer                seed;

    pcpu_top dut0 (
        .clk      (clk),
        .reset    (reset),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .im_addr  (im_addr),
        .im_data  (im_data),
        .dm_addr  (dm_addr),
        .dm_we    (dm_we),
        .dm_wdata (dm_wdata),
        .dm_rdata (dm_rdata)
    );

    always #2 clk = ~clk;

    // ************************************************************************
    // memory models, word addressed, combinational read
    // ************************************************************************

    assign im_data  = imem[im_addr[7:0]];
    assign dm_rdata = dmem[dm_addr[7:0]];

    always @(posedge clk) begin
        if (dm_we)
            dmem[dm_addr[7:0]] <= dm_wdata;
    end

    `include "pcpu_tb_tasks.svh"

    // ************************************************************************
    // test sequence
    // ************************************************************************

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        reg_addr  = '0;
        seed      = 36963;
        halt_addr = '0;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = '0;

        reset_behavior();
        alu_forwarding_chain();
        zero_register_rules();
        load_store_roundtrip();
        branch_paths();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
